// File: hw/riscv_pkg.sv
package riscv_pkg;

    // datapath and register file geometry.
    localparam int unsigned XLEN       = 32;
    localparam int unsigned ILEN       = 32;
    localparam int unsigned REG_ADDR_W = 5;
    localparam int unsigned NUM_REGS   = 32;

    // major opcodes, instr[6:0].
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    // funct3, instr[14:12].
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct7 for SUB and SRA/SRAI.
    localparam logic [6:0] F7_ALT = 7'b0100000;

endpackage

// File: hw/core_pkg.sv
package core_pkg;

    // NOP sits at zero so a cleared stage decodes as a bubble.
    typedef enum logic [3:0] {
        ALU_NOP   = 4'd0,
        ALU_ADD   = 4'd1,
        ALU_SUB   = 4'd2,
        ALU_OR    = 4'd3,
        ALU_AND   = 4'd4,
        ALU_XOR   = 4'd5,
        ALU_SLL   = 4'd6,
        ALU_SLT   = 4'd7,
        ALU_SLTU  = 4'd8,
        ALU_SRL   = 4'd9,
        ALU_SRA   = 4'd10,
        ALU_LUI   = 4'd11,
        ALU_AUIPC = 4'd12
    } alu_op_e;

    typedef enum logic [1:0] {
        R_FORMAT = 2'd0,
        I_FORMAT = 2'd1,
        U_FORMAT = 2'd2
    } format_e;

    // one instruction as it moves from decode to execute.
    typedef struct packed {
        logic [riscv_pkg::XLEN-1:0]       pc;
        format_e                          format;
        alu_op_e                          alu_op;
        logic [riscv_pkg::REG_ADDR_W-1:0] rs1_addr;
        logic [riscv_pkg::REG_ADDR_W-1:0] rs2_addr;
        logic [riscv_pkg::XLEN-1:0]       rs1_data;
        logic [riscv_pkg::XLEN-1:0]       rs2_data;
        logic [riscv_pkg::XLEN-1:0]       imm;
        logic [riscv_pkg::REG_ADDR_W-1:0] rd_addr;
        logic                             rd_we;
        logic [riscv_pkg::XLEN-1:0]       rd_res;
    } pipeline_bus_t;

    typedef struct packed {
        logic [riscv_pkg::REG_ADDR_W-1:0] rd_addr;
        logic                             rd_we;
        logic [riscv_pkg::XLEN-1:0]       rd_res;
    } wb_bus_t;

endpackage

// File: hw/regfile_if.sv
interface regfile_if;

    logic [riscv_pkg::REG_ADDR_W-1:0] rs1_addr;
    logic [riscv_pkg::REG_ADDR_W-1:0] rs2_addr;
    logic [riscv_pkg::XLEN-1:0]       rs1_data;
    logic [riscv_pkg::XLEN-1:0]       rs2_data;

    // decode side.
    modport requester (
        output rs1_addr, rs2_addr,
        input  rs1_data, rs2_data
    );

    // register file side.
    modport provider (
        input  rs1_addr, rs2_addr,
        output rs1_data, rs2_data
    );

endinterface

// File: hw/regfile.sv
module regfile (
    input  logic                             clk,
    input  logic                             arst_n_i,
    regfile_if.provider                      rd_port_i,
    input  logic                             wr_en_i,
    input  logic [riscv_pkg::REG_ADDR_W-1:0] wr_addr_i,
    input  logic [riscv_pkg::XLEN-1:0]       wr_data_i
);

    logic [riscv_pkg::XLEN-1:0] regs_q   [1:riscv_pkg::NUM_REGS-1];
    logic [riscv_pkg::XLEN-1:0] rd_view  [0:riscv_pkg::NUM_REGS-1];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < riscv_pkg::NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en_i && (wr_addr_i != '0)) begin
            regs_q[wr_addr_i] <= wr_data_i;
        end
    end

    // read view with same-cycle write forwarded.
    always_comb begin
        rd_view[0] = '0;
        for (int i = 1; i < riscv_pkg::NUM_REGS; i++) begin
            if (wr_en_i && (wr_addr_i == i[riscv_pkg::REG_ADDR_W-1:0])) begin
                rd_view[i] = wr_data_i;
            end else begin
                rd_view[i] = regs_q[i];
            end
        end
    end

    assign rd_port_i.rs1_data = rd_view[rd_port_i.rs1_addr];
    assign rd_port_i.rs2_data = rd_view[rd_port_i.rs2_addr];

endmodule

// File: hw/decoder.sv
module decoder (
    input  logic [riscv_pkg::ILEN-1:0] instr_i,
    input  logic [riscv_pkg::XLEN-1:0] pc_i,
    regfile_if.requester               rf_rd_o,
    output core_pkg::pipeline_bus_t    bus_o
);

    logic [6:0]                       opcode;
    logic [2:0]                       funct3;
    logic                             alt;
    logic [riscv_pkg::XLEN-1:0]       imm_i;
    logic [riscv_pkg::XLEN-1:0]       imm_u;
    logic [riscv_pkg::XLEN-1:0]       imm_shamt;
    logic [riscv_pkg::REG_ADDR_W-1:0] rd_addr;

    function automatic core_pkg::alu_op_e decode_op(
        input logic [2:0] f3,
        input logic       alt_sel,
        input logic       is_imm
    );
        core_pkg::alu_op_e op;
        unique case (f3)
            riscv_pkg::F3_ADD_SUB: begin
                // ADDI has no subtract form.
                op = (alt_sel && !is_imm) ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
            end
            riscv_pkg::F3_SLL:  op = core_pkg::ALU_SLL;
            riscv_pkg::F3_SLT:  op = core_pkg::ALU_SLT;
            riscv_pkg::F3_SLTU: op = core_pkg::ALU_SLTU;
            riscv_pkg::F3_XOR:  op = core_pkg::ALU_XOR;
            riscv_pkg::F3_SR:   op = alt_sel ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
            riscv_pkg::F3_OR:   op = core_pkg::ALU_OR;
            riscv_pkg::F3_AND:  op = core_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    assign opcode  = instr_i[6:0];
    assign funct3  = instr_i[14:12];
    assign alt     = (instr_i[31:25] == riscv_pkg::F7_ALT);
    assign rd_addr = instr_i[11:7];

    assign imm_i     = {{(riscv_pkg::XLEN-12){instr_i[31]}}, instr_i[31:20]};
    assign imm_u     = {instr_i[31:12], 12'b0};
    assign imm_shamt = {{(riscv_pkg::XLEN-5){1'b0}}, instr_i[24:20]};

    assign rf_rd_o.rs1_addr = instr_i[19:15];
    assign rf_rd_o.rs2_addr = instr_i[24:20];

    always_comb begin
        bus_o          = '0;
        bus_o.pc       = pc_i;
        bus_o.rs1_addr = instr_i[19:15];
        bus_o.rs2_addr = instr_i[24:20];
        bus_o.rs1_data = rf_rd_o.rs1_data;
        bus_o.rs2_data = rf_rd_o.rs2_data;
        bus_o.rd_addr  = rd_addr;
        bus_o.format   = core_pkg::R_FORMAT;
        bus_o.alu_op   = core_pkg::ALU_NOP;

        unique case (opcode)
            riscv_pkg::OPC_OP: begin
                bus_o.alu_op = decode_op(funct3, alt, 1'b0);
                bus_o.rd_we  = 1'b1;
            end
            riscv_pkg::OPC_OP_IMM: begin
                bus_o.format = core_pkg::I_FORMAT;
                bus_o.alu_op = decode_op(funct3, alt, 1'b1);
                bus_o.rd_we  = 1'b1;
                // shifts keep only the shamt field.
                if ((funct3 == riscv_pkg::F3_SLL) || (funct3 == riscv_pkg::F3_SR)) begin
                    bus_o.imm = imm_shamt;
                end else begin
                    bus_o.imm = imm_i;
                end
            end
            riscv_pkg::OPC_LUI: begin
                bus_o.format = core_pkg::U_FORMAT;
                bus_o.alu_op = core_pkg::ALU_LUI;
                bus_o.imm    = imm_u;
                bus_o.rd_we  = 1'b1;
            end
            riscv_pkg::OPC_AUIPC: begin
                bus_o.format = core_pkg::U_FORMAT;
                bus_o.alu_op = core_pkg::ALU_AUIPC;
                bus_o.imm    = imm_u;
                bus_o.rd_we  = 1'b1;
            end
            default: begin
                bus_o.rd_we = 1'b0;
            end
        endcase

        // x0 is never written.
        if (rd_addr == '0) begin
            bus_o.rd_we = 1'b0;
        end
    end

endmodule

// File: hw/operand_bypass.sv
module operand_bypass (
    input  core_pkg::pipeline_bus_t bus_i,
    input  logic                    ex_valid_i,
    input  core_pkg::pipeline_bus_t ex_bus_i,
    output core_pkg::pipeline_bus_t bus_o
);

    logic fwd_en;
    logic fwd_rs1;
    logic fwd_rs2;

    // x0 is never a forwarding source.
    assign fwd_en  = ex_valid_i && ex_bus_i.rd_we && (ex_bus_i.rd_addr != '0);
    assign fwd_rs1 = fwd_en && (bus_i.rs1_addr == ex_bus_i.rd_addr);
    assign fwd_rs2 = fwd_en && (bus_i.rs2_addr == ex_bus_i.rd_addr);

    always_comb begin
        bus_o = bus_i;
        if (fwd_rs1) begin
            bus_o.rs1_data = ex_bus_i.rd_res;
        end
        if (fwd_rs2) begin
            bus_o.rs2_data = ex_bus_i.rd_res;
        end
    end

endmodule

// File: hw/alu.sv
module alu (
    input  core_pkg::pipeline_bus_t alu_bus_i,
    output core_pkg::pipeline_bus_t alu_bus_o
);

    logic [riscv_pkg::XLEN-1:0] op_a;
    logic [riscv_pkg::XLEN-1:0] op_b;
    logic [4:0]                 shamt;
    logic                       lt_signed;
    logic                       lt_unsigned;

    assign op_a = alu_bus_i.rs1_data;

    // second operand by format.
    always_comb begin
        unique case (alu_bus_i.format)
            core_pkg::I_FORMAT: op_b = alu_bus_i.imm;
            core_pkg::R_FORMAT: op_b = alu_bus_i.rs2_data;
            default:            op_b = alu_bus_i.imm;
        endcase
    end

    assign shamt       = op_b[4:0];
    assign lt_signed   = $signed(op_a) < $signed(op_b);
    assign lt_unsigned = op_a < op_b;

    always_comb begin : arithmetic_unit
        alu_bus_o        = alu_bus_i;
        alu_bus_o.rd_res = '0;

        case (alu_bus_i.alu_op)
            core_pkg::ALU_ADD: begin
                alu_bus_o.rd_res = op_a + op_b;
            end
            core_pkg::ALU_SUB: begin
                alu_bus_o.rd_res = op_a - op_b;
            end
            core_pkg::ALU_OR: begin
                alu_bus_o.rd_res = op_a | op_b;
            end
            core_pkg::ALU_AND: begin
                alu_bus_o.rd_res = op_a & op_b;
            end
            core_pkg::ALU_XOR: begin
                alu_bus_o.rd_res = op_a ^ op_b;
            end
            core_pkg::ALU_SLL: begin
                alu_bus_o.rd_res = op_a << shamt;
            end
            core_pkg::ALU_SLT: begin
                alu_bus_o.rd_res = {{(riscv_pkg::XLEN-1){1'b0}}, lt_signed};
            end
            core_pkg::ALU_SLTU: begin
                alu_bus_o.rd_res = {{(riscv_pkg::XLEN-1){1'b0}}, lt_unsigned};
            end
            core_pkg::ALU_SRL: begin
                alu_bus_o.rd_res = op_a >> shamt;
            end
            core_pkg::ALU_SRA: begin
                // arithmetic shift keeps the sign bit.
                alu_bus_o.rd_res = $unsigned($signed(op_a) >>> shamt);
            end
            core_pkg::ALU_LUI: begin
                alu_bus_o.rd_res = alu_bus_i.imm;
            end
            core_pkg::ALU_AUIPC: begin
                alu_bus_o.rd_res = alu_bus_i.imm + alu_bus_i.pc;
            end
            core_pkg::ALU_NOP: begin
                alu_bus_o.rd_res = '0;
            end
            default: begin
                alu_bus_o.rd_res = '0;
            end
        endcase
    end

endmodule

// File: hw/stage_reg.sv
module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     arst_n_i,
    input  logic     valid_i,
    input  payload_t data_i,
    output logic     valid_o,
    output payload_t data_o
);

    // payload advances every cycle, valid qualifies it.
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o <= 1'b0;
            data_o  <= '0;
        end else begin
            valid_o <= valid_i;
            data_o  <= data_i;
        end
    end

endmodule

// File: hw/int_pipe_top.sv
module int_pipe_top (
    input  logic                             clk,
    input  logic                             arst_n_i,
    input  logic                             instr_valid_i,
    input  logic [riscv_pkg::ILEN-1:0]       instr_i,
    input  logic [riscv_pkg::XLEN-1:0]       pc_i,
    output logic                             wb_valid_o,
    output logic [riscv_pkg::REG_ADDR_W-1:0] wb_rd_o,
    output logic [riscv_pkg::XLEN-1:0]       wb_data_o
);

    core_pkg::pipeline_bus_t dec_bus;
    core_pkg::pipeline_bus_t byp_bus;
    core_pkg::pipeline_bus_t ex_bus;
    core_pkg::pipeline_bus_t alu_bus;
    core_pkg::wb_bus_t       wb_next;
    core_pkg::wb_bus_t       wb_bus;
    logic                    ex_valid;
    logic                    wb_valid;
    logic                    wb_write;

    regfile_if rf_rd_if ();

    decoder decoder_i (
        .instr_i (instr_i),
        .pc_i    (pc_i),
        .rf_rd_o (rf_rd_if.requester),
        .bus_o   (dec_bus)
    );

    operand_bypass bypass_i (
        .bus_i      (dec_bus),
        .ex_valid_i (ex_valid),
        .ex_bus_i   (alu_bus),
        .bus_o      (byp_bus)
    );

    stage_reg #(
        .payload_t (core_pkg::pipeline_bus_t)
    ) ex_reg_i (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .valid_i  (instr_valid_i),
        .data_i   (byp_bus),
        .valid_o  (ex_valid),
        .data_o   (ex_bus)
    );

    alu alu_i (
        .alu_bus_i (ex_bus),
        .alu_bus_o (alu_bus)
    );

    // bubbles in execute must not reach the register file.
    always_comb begin
        wb_next.rd_addr = alu_bus.rd_addr;
        wb_next.rd_we   = ex_valid && alu_bus.rd_we;
        wb_next.rd_res  = alu_bus.rd_res;
    end

    stage_reg #(
        .payload_t (core_pkg::wb_bus_t)
    ) wb_reg_i (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .valid_i  (ex_valid),
        .data_i   (wb_next),
        .valid_o  (wb_valid),
        .data_o   (wb_bus)
    );

    assign wb_write = wb_valid && wb_bus.rd_we;

    regfile regfile_i (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .rd_port_i (rf_rd_if.provider),
        .wr_en_i   (wb_write),
        .wr_addr_i (wb_bus.rd_addr),
        .wr_data_i (wb_bus.rd_res)
    );

    assign wb_valid_o = wb_write;
    assign wb_rd_o    = wb_bus.rd_addr;
    assign wb_data_o  = wb_bus.rd_res;

endmodule

// File: sim/tb_clk_gen.sv
module tb_clk_gen #(
    parameter int PERIOD     = 40,
    parameter int RST_CYCLES = 10
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD / 2);
            clk_o = ~clk_o;
        end
    end

    // release just after an edge.
    initial begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        #(PERIOD / 8);
        rst_n_o = 1'b1;
    end

endmodule

// File: sim/int_pipe_asserts.sv
module int_pipe_asserts (
    input logic       clk,
    input logic       arst_n_i,
    input logic       instr_valid_i,
    input logic       wb_valid_i,
    input logic [4:0] wb_rd_i
);

    int unsigned fail_count = 0;

    // x0 is never reported as written.
    property no_wb_to_x0;
        @(posedge clk) disable iff (!arst_n_i) wb_valid_i |-> (wb_rd_i != '0);
    endproperty

    // two-cycle latency from issue to writeback.
    property wb_follows_issue;
        @(posedge clk) disable iff (!arst_n_i) wb_valid_i |-> $past(instr_valid_i, 2);
    endproperty

    property quiet_in_reset;
        @(posedge clk) !arst_n_i |-> !wb_valid_i;
    endproperty

    no_wb_to_x0_a: assert property (no_wb_to_x0)
        else begin
            $error("writeback reported for register x0");
            fail_count++;
        end
    wb_follows_issue_a: assert property (wb_follows_issue)
        else begin
            $error("writeback without an instruction two cycles earlier");
            fail_count++;
        end
    quiet_in_reset_a: assert property (quiet_in_reset)
        else begin
            $error("writeback valid while reset is asserted");
            fail_count++;
        end

endmodule

bind int_pipe_top int_pipe_asserts asserts_i (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .instr_valid_i (instr_valid_i),
    .wb_valid_i    (wb_valid_o),
    .wb_rd_i       (wb_rd_o)
);

// File: sim/int_pipe_tb.sv
module int_pipe_tb;

    logic        clk;
    logic        rst_n;
    logic        instr_valid;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;

    // stimulus table.
    logic [31:0] tbl_instr [$];
    logic [31:0] tbl_pc    [$];
    logic [4:0]  tbl_rd    [$];
    logic [31:0] tbl_data  [$];
    logic [31:0] next_pc;

    // in-flight expectations tagged with the issue cycle.
    int          issue_q    [$];
    logic [4:0]  exp_rd_q   [$];
    logic [31:0] exp_data_q [$];

    logic [31:0] lfsr_state;
    int cyc             = 0;
    int timeout_limit   = 0;
    int mismatch_errs   = 0;
    int missing_errs    = 0;
    int unexpected_errs = 0;
    int timeout_errs    = 0;

    tb_clk_gen #(
        .PERIOD     (40),
        .RST_CYCLES (10)
    ) clk_gen_i (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    int_pipe_top dut_i (
        .clk           (clk),
        .arst_n_i      (rst_n),
        .instr_valid_i (instr_valid),
        .instr_i       (instr),
        .pc_i          (pc),
        .wb_valid_o    (wb_valid),
        .wb_rd_o       (wb_rd),
        .wb_data_o     (wb_data)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic [31:0] nxt_state;
        nxt_state = state >> 1;
        if (state[0]) begin
            nxt_state = nxt_state ^ 32'h80200003;
        end
        return nxt_state;
    endfunction

    function automatic logic [31:0] imm_word(input logic [2:0] f3, input logic [4:0] rd,
                                             input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, riscv_pkg::OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] reg_word(input logic [6:0] f7, input logic [2:0] f3,
                                             input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, riscv_pkg::OPC_OP};
    endfunction

    function automatic logic [31:0] upper_word(input logic [6:0] opc, input logic [4:0] rd,
                                               input logic [19:0] imm);
        return {imm, rd, opc};
    endfunction

    task automatic add_entry(input logic [31:0] word, input logic [4:0] rd,
                             input logic [31:0] data);
        tbl_instr.push_back(word);
        tbl_pc.push_back(next_pc);
        tbl_rd.push_back(rd);
        tbl_data.push_back(data);
        next_pc = next_pc + 32'd4;
    endtask

    task automatic build_table();
        next_pc = 32'h0000_0100;
        add_entry(imm_word(riscv_pkg::F3_ADD_SUB, 5'd1, 5'd0, 12'd5), 5'd1, 32'h5);
        add_entry(imm_word(riscv_pkg::F3_ADD_SUB, 5'd2, 5'd0, 12'hffd), 5'd2, 32'hfffffffd);
        add_entry(reg_word(7'd0, riscv_pkg::F3_ADD_SUB, 5'd3, 5'd1, 5'd2), 5'd3, 32'h2);
        add_entry(reg_word(riscv_pkg::F7_ALT, riscv_pkg::F3_ADD_SUB, 5'd4, 5'd1, 5'd2),
                  5'd4, 32'h8);
        add_entry(reg_word(7'd0, riscv_pkg::F3_AND, 5'd5, 5'd1, 5'd2), 5'd5, 32'h5);
        add_entry(reg_word(7'd0, riscv_pkg::F3_OR, 5'd6, 5'd1, 5'd2), 5'd6, 32'hfffffffd);
        add_entry(reg_word(7'd0, riscv_pkg::F3_XOR, 5'd7, 5'd1, 5'd2), 5'd7, 32'hfffffff8);
        add_entry(reg_word(7'd0, riscv_pkg::F3_SLT, 5'd8, 5'd2, 5'd1), 5'd8, 32'h1);
        add_entry(reg_word(7'd0, riscv_pkg::F3_SLTU, 5'd9, 5'd2, 5'd1), 5'd9, 32'h0);
        add_entry(imm_word(riscv_pkg::F3_AND, 5'd10, 5'd2, 12'h0f0), 5'd10, 32'hf0);
        add_entry(imm_word(riscv_pkg::F3_OR, 5'd11, 5'd1, 12'hff0), 5'd11, 32'hfffffff5);
        add_entry(imm_word(riscv_pkg::F3_XOR, 5'd12, 5'd1, 12'h7ff), 5'd12, 32'h7fa);
        add_entry(imm_word(riscv_pkg::F3_SLT, 5'd13, 5'd2, 12'hffe), 5'd13, 32'h1);
        add_entry(imm_word(riscv_pkg::F3_SLTU, 5'd14, 5'd1, 12'hfff), 5'd14, 32'h1);
        add_entry(imm_word(riscv_pkg::F3_SLTU, 5'd15, 5'd2, 12'd3), 5'd15, 32'h0);
        add_entry(upper_word(riscv_pkg::OPC_LUI, 5'd16, 20'h80000), 5'd16, 32'h80000000);
        add_entry(imm_word(riscv_pkg::F3_SR, 5'd17, 5'd16, {riscv_pkg::F7_ALT, 5'd4}),
                  5'd17, 32'hf8000000);
        add_entry(imm_word(riscv_pkg::F3_SR, 5'd18, 5'd16, 12'd4), 5'd18, 32'h08000000);
        add_entry(imm_word(riscv_pkg::F3_SLL, 5'd19, 5'd1, 12'd31), 5'd19, 32'h80000000);
        // amount 35 leaves 3 in the low 5 bits.
        add_entry(imm_word(riscv_pkg::F3_ADD_SUB, 5'd20, 5'd0, 12'd35), 5'd20, 32'h23);
        add_entry(reg_word(7'd0, riscv_pkg::F3_SLL, 5'd21, 5'd1, 5'd20), 5'd21, 32'h28);
        add_entry(reg_word(7'd0, riscv_pkg::F3_SR, 5'd22, 5'd16, 5'd20), 5'd22, 32'h10000000);
        add_entry(reg_word(riscv_pkg::F7_ALT, riscv_pkg::F3_SR, 5'd23, 5'd16, 5'd20),
                  5'd23, 32'hf0000000);
        next_pc = 32'h0000_2468;
        add_entry(upper_word(riscv_pkg::OPC_AUIPC, 5'd24, 20'h12345), 5'd24, 32'h12347468);
        // write to x0, then a load opcode.
        add_entry(imm_word(riscv_pkg::F3_ADD_SUB, 5'd0, 5'd1, 12'd7), 5'd0, 32'h0);
        add_entry({12'd0, 5'd1, 3'b010, 5'd25, 7'b0000011}, 5'd0, 32'h0);
        add_entry(reg_word(7'd0, riscv_pkg::F3_ADD_SUB, 5'd26, 5'd0, 5'd1), 5'd26, 32'h5);
        add_entry(reg_word(7'd0, riscv_pkg::F3_ADD_SUB, 5'd27, 5'd25, 5'd1), 5'd27, 32'h5);
        add_entry(imm_word(riscv_pkg::F3_ADD_SUB, 5'd28, 5'd28, 12'd1), 5'd28, 32'h1);
        add_entry(imm_word(riscv_pkg::F3_ADD_SUB, 5'd28, 5'd28, 12'd1), 5'd28, 32'h2);
        add_entry(imm_word(riscv_pkg::F3_ADD_SUB, 5'd28, 5'd28, 12'd1), 5'd28, 32'h3);
        add_entry(reg_word(7'd0, riscv_pkg::F3_ADD_SUB, 5'd29, 5'd28, 5'd28), 5'd29, 32'h6);
        add_entry(reg_word(riscv_pkg::F7_ALT, riscv_pkg::F3_ADD_SUB, 5'd30, 5'd2, 5'd29),
                  5'd30, 32'hfffffff7);
        add_entry(reg_word(7'd0, riscv_pkg::F3_SLT, 5'd31, 5'd30, 5'd2), 5'd31, 32'h1);
        add_entry(reg_word(7'd0, riscv_pkg::F3_SLTU, 5'd8, 5'd30, 5'd1), 5'd8, 32'h0);
    endtask

    task automatic drive_slot(input logic valid, input logic [31:0] word,
                              input logic [31:0] addr);
        @(posedge clk);
        #5;
        instr_valid = valid;
        instr       = word;
        pc          = addr;
    endtask

    task automatic check_cycle();
        logic [4:0]  exp_rd;
        logic [31:0] exp_data;
        if ((issue_q.size() > 0) && (issue_q[0] + 2 == cyc)) begin
            void'(issue_q.pop_front());
            exp_rd   = exp_rd_q.pop_front();
            exp_data = exp_data_q.pop_front();
            if (exp_rd == 5'd0) begin
                if (wb_valid !== 1'b0) begin
                    $display("t=%0t writeback for an instruction that must not write",
                             $time);
                    unexpected_errs++;
                end
            end else if (wb_valid !== 1'b1) begin
                $display("t=%0t writeback to x%0d did not appear", $time, exp_rd);
                missing_errs++;
            end else begin
                if (wb_rd !== exp_rd) begin
                    $display("MISMATCH t=%0t wb_rd_o expected %0d actual %0d",
                             $time, exp_rd, wb_rd);
                    mismatch_errs++;
                end
                if (wb_data !== exp_data) begin
                    $display("MISMATCH t=%0t wb_data_o expected %h actual %h",
                             $time, exp_data, wb_data);
                    mismatch_errs++;
                end
            end
        end else if (wb_valid !== 1'b0) begin
            $display("t=%0t writeback appeared with no instruction in flight", $time);
            unexpected_errs++;
        end
    endtask

    task automatic finish_run();
        int total;
        int assert_errs;
        assert_errs = dut_i.asserts_i.fail_count;
        total = mismatch_errs + missing_errs + unexpected_errs + timeout_errs + assert_errs;
        $display("errors: mismatch %0d, missing %0d, unexpected %0d, timeout %0d, assertion %0d",
                 mismatch_errs, missing_errs, unexpected_errs, timeout_errs, assert_errs);
        if (total == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    endtask

    always @(posedge clk) begin
        cyc = cyc + 1;
        if ((timeout_limit > 0) && (cyc >= timeout_limit)) begin
            $display("timeout after %0d cycles with writebacks still pending", cyc);
            timeout_errs++;
            finish_run();
        end
    end

    always @(negedge clk) begin
        if (rst_n) begin
            check_cycle();
        end
    end

    initial begin : stimulus
        logic gap;
        instr_valid = 1'b0;
        instr       = '0;
        pc          = '0;
        lfsr_state  = 32'ha416b332;
        build_table();
        timeout_limit = 10 + 2 * tbl_instr.size() + 20;
        wait (rst_n === 1'b1);
        for (int i = 0; i < tbl_instr.size(); i++) begin
            gap        = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
            if (gap) begin
                drive_slot(1'b0, '0, '0);
            end
            drive_slot(1'b1, tbl_instr[i], tbl_pc[i]);
            issue_q.push_back(cyc);
            exp_rd_q.push_back(tbl_rd[i]);
            exp_data_q.push_back(tbl_data[i]);
        end
        drive_slot(1'b0, '0, '0);
        wait (issue_q.size() == 0);
        // a few idle cycles must stay quiet.
        repeat (4) @(posedge clk);
        finish_run();
    end

endmodule

// File: tb.f
hw/riscv_pkg.sv
hw/core_pkg.sv
hw/regfile_if.sv
hw/regfile.sv
hw/decoder.sv
hw/operand_bypass.sv
hw/alu.sv
hw/stage_reg.sv
hw/int_pipe_top.sv
sim/tb_clk_gen.sv
sim/int_pipe_asserts.sv
sim/int_pipe_tb.sv

// File: Bender.yml
package:
  name: int_pipe

sources:
  - files:
      - hw/riscv_pkg.sv
      - hw/core_pkg.sv
      - hw/regfile_if.sv
      - hw/regfile.sv
      - hw/decoder.sv
      - hw/operand_bypass.sv
      - hw/alu.sv
      - hw/stage_reg.sv
      - hw/int_pipe_top.sv
  - target: simulation
    files:
      - sim/tb_clk_gen.sv
      - sim/int_pipe_asserts.sv
      - sim/int_pipe_tb.sv
